// ==== logic/cpuPkg.sv ====
package cpuPkg;

    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int imemDepth = 64;                 // Words of program ROM
    localparam int dmemDepth = 64;                 // Words of data RAM
    localparam int imemAw    = $clog2(imemDepth);
    localparam int dmemAw    = $clog2(dmemDepth);

    typedef logic [xlen-1:0]     word_t;
    typedef logic [regAddrW-1:0] regIdx_t;

    // RV32I major opcodes in use
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    typedef struct packed {
        logic    regWrite;
        logic    aluSrcImm;   // Second operand from immediate
        logic    memWrite;
        logic    memToReg;
        logic    branch;
        logic    branchNe;    // bne instead of beq
        aluOp_t  aluOp;
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        word_t   imm;
    } ctrl_t;

    // One record per retired instruction
    typedef struct packed {
        logic    valid;
        word_t   pc;
        word_t   inst;
        regIdx_t rd;
        logic    regWrite;
        word_t   wdata;
        logic    memWrite;
        word_t   memAddr;
        word_t   memData;
        word_t   nextPc;
    } retire_t;

endpackage

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic           CLK,
    input  logic           arstN,
    input  logic           branchTaken,
    input  cpuPkg::word_t  branchTarget,
    output cpuPkg::word_t  pc,
    output cpuPkg::word_t  inst
);

    // Program image, read only
    cpuPkg::word_t rom [cpuPkg::imemDepth];

    cpuPkg::word_t pcPlus4;
    cpuPkg::word_t pcNext;
    logic [cpuPkg::imemAw-1:0] romIdx;

    initial begin
        $readmemh("prog.hex", rom);
    end

    assign pcPlus4 = pc + 32'd4;
    assign pcNext  = branchTaken ? branchTarget : pcPlus4;

    // Word index, byte offset dropped
    assign romIdx = pc[cpuPkg::imemAw+1:2];
    assign inst   = rom[romIdx];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Branch targets come from execute, so a bad immediate would show up here
    pcAligned: assert property (
        @(posedge CLK) disable iff (!arstN)
        pc[1:0] == 2'b00
    ) else $error("fetchUnit: pc %h not word aligned", pc);

endmodule

// ==== logic/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
    input  cpuPkg::word_t inst,
    output cpuPkg::ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    cpuPkg::word_t immI;
    cpuPkg::word_t immS;
    cpuPkg::word_t immB;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    // Sign extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        ctrl       = '0;               // Unknown opcode acts as nop
        ctrl.aluOp = cpuPkg::aluAdd;
        ctrl.rs1   = inst[19:15];
        ctrl.rs2   = inst[24:20];
        ctrl.rd    = inst[11:7];

        case (opcode)
            cpuPkg::opReg: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7b5 ? cpuPkg::aluSub : cpuPkg::aluAdd;
                    3'b010:  ctrl.aluOp = cpuPkg::aluSlt;
                    3'b110:  ctrl.aluOp = cpuPkg::aluOr;
                    3'b111:  ctrl.aluOp = cpuPkg::aluAnd;
                    default: ctrl.regWrite = 1'b0;   // Shifts etc. not supported
                endcase
            end
            cpuPkg::opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
                case (funct3)
                    3'b000:  ctrl.aluOp = cpuPkg::aluAdd;
                    3'b110:  ctrl.aluOp = cpuPkg::aluOr;
                    3'b111:  ctrl.aluOp = cpuPkg::aluAnd;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            cpuPkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.imm       = immI;
            end
            cpuPkg::opStore: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.imm       = immS;
            end
            cpuPkg::opBranch: begin
                ctrl.aluOp = cpuPkg::aluSub;  // Compare by subtraction
                ctrl.imm   = immB;
                // Only beq and bne
                ctrl.branch   = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.branchNe = funct3[0];
            end
            default: begin
                ctrl.rd = '0;
            end
        endcase
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic            CLK,
    input  logic            arstN,
    input  cpuPkg::regIdx_t rs1,
    input  cpuPkg::regIdx_t rs2,
    output cpuPkg::word_t   rd1,
    output cpuPkg::word_t   rd2,
    input  logic            wbEn,
    input  cpuPkg::regIdx_t wbRd,
    input  cpuPkg::word_t   wbData
);

    cpuPkg::word_t regs [2**cpuPkg::regAddrW];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**cpuPkg::regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbRd != '0)) begin
            regs[wbRd] <= wbData;   // x0 never written
        end
    end

    // Zero latency reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // Write enable comes from execute and must be gated there during reset
    noWriteInReset: assert property (
        @(posedge CLK) !arstN |-> !wbEn
    ) else $error("regFile: write enable seen during reset");

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
    input  cpuPkg::word_t   pc,
    input  cpuPkg::word_t   inst,
    input  cpuPkg::ctrl_t   ctrl,
    input  cpuPkg::word_t   rd1,
    input  cpuPkg::word_t   rd2,
    input  cpuPkg::word_t   memRdata,
    input  logic            arstN,
    output cpuPkg::word_t   memAddr,
    output cpuPkg::word_t   memWdata,
    output logic            memWe,
    output logic            wbEn,
    output cpuPkg::regIdx_t wbRd,
    output cpuPkg::word_t   wbData,
    output logic            branchTaken,
    output cpuPkg::word_t   branchTarget,
    output cpuPkg::retire_t retire
);

    cpuPkg::word_t aluB;
    cpuPkg::word_t aluResult;
    cpuPkg::word_t pcPlus4;
    logic          aluZero;

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rd2;

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd: aluResult = rd1 + aluB;
            cpuPkg::aluSub: aluResult = rd1 - aluB;
            cpuPkg::aluAnd: aluResult = rd1 & aluB;
            cpuPkg::aluOr:  aluResult = rd1 | aluB;
            cpuPkg::aluSlt: begin
                // Signed compare
                aluResult = {31'b0, $signed(rd1) < $signed(aluB)};
            end
            default:        aluResult = '0;
        endcase
    end

    assign aluZero = (aluResult == '0);

    // beq on zero, bne on nonzero
    assign branchTaken  = ctrl.branch && (aluZero ^ ctrl.branchNe);
    assign branchTarget = pc + ctrl.imm;
    assign pcPlus4      = pc + 32'd4;

    assign memAddr  = aluResult;
    assign memWdata = rd2;
    assign memWe    = ctrl.memWrite && arstN;

    assign wbRd   = ctrl.rd;
    assign wbEn   = ctrl.regWrite && (ctrl.rd != '0) && arstN;   // x0 shows as no write
    assign wbData = ctrl.memToReg ? memRdata : aluResult;

    always_comb begin
        retire.valid    = arstN;
        retire.pc       = pc;
        retire.inst     = inst;
        retire.rd       = wbRd;
        retire.regWrite = wbEn;
        retire.wdata    = wbData;
        retire.memWrite = memWe;
        retire.memAddr  = memAddr;
        retire.memData  = memWdata;
        retire.nextPc   = branchTaken ? branchTarget : pcPlus4;
    end

endmodule

// ==== logic/dataMem.sv ====
`timescale 1ns/1ps

module dataMem (
    input  logic          CLK,
    input  cpuPkg::word_t addr,
    input  cpuPkg::word_t wdata,
    input  logic          we,
    output cpuPkg::word_t rdata
);

    cpuPkg::word_t ram [cpuPkg::dmemDepth];

    logic [cpuPkg::dmemAw-1:0] wordIdx;

    // Upper address bits wrap
    assign wordIdx = addr[cpuPkg::dmemAw+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            ram[wordIdx] <= wdata;
        end
    end

    assign rdata = ram[wordIdx];   // Combinational read

    // Only whole-word stores exist in this core
    storeAligned: assert property (
        @(posedge CLK) we |-> (addr[1:0] == 2'b00)
    ) else $error("dataMem: misaligned store to %h", addr);

endmodule

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
    input  logic            CLK,
    input  logic            arstN,
    output cpuPkg::retire_t retire
);

    cpuPkg::word_t   pc;
    cpuPkg::word_t   inst;
    cpuPkg::ctrl_t   ctrl;
    cpuPkg::word_t   rd1;
    cpuPkg::word_t   rd2;
    cpuPkg::word_t   memAddr;
    cpuPkg::word_t   memWdata;
    cpuPkg::word_t   memRdata;
    logic            memWe;
    logic            wbEn;
    cpuPkg::regIdx_t wbRd;
    cpuPkg::word_t   wbData;
    logic            branchTaken;
    cpuPkg::word_t   branchTarget;

    fetchUnit u_fetchUnit (
        .CLK          (CLK),
        .arstN        (arstN),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .inst         (inst)
    );

    decodeUnit u_decodeUnit (
        .inst (inst),
        .ctrl (ctrl)
    );

    // Reads in parallel with decode
    regFile u_regFile (
        .CLK    (CLK),
        .arstN  (arstN),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd1    (rd1),
        .rd2    (rd2),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

    executeUnit u_executeUnit (
        .pc           (pc),
        .inst         (inst),
        .ctrl         (ctrl),
        .rd1          (rd1),
        .rd2          (rd2),
        .memRdata     (memRdata),
        .arstN        (arstN),
        .memAddr      (memAddr),
        .memWdata     (memWdata),
        .memWe        (memWe),
        .wbEn         (wbEn),
        .wbRd         (wbRd),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .retire       (retire)
    );

    dataMem u_dataMem (
        .CLK   (CLK),
        .addr  (memAddr),
        .wdata (memWdata),
        .we    (memWe),
        .rdata (memRdata)
    );

endmodule

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    localparam int runCycles = 60;

    logic            CLK;
    logic            arstN;
    cpuPkg::retire_t retire;

    int errCount;
    int cycles;

    // Shadow architectural state
    cpuPkg::word_t shadowReg [32];
    cpuPkg::word_t shadowMem [64];
    logic          memKnown  [64];   // Word written by a store
    cpuPkg::word_t shadowPc;
    logic          seenRetire;
    logic          loopReached;

    // Fields of the retiring instruction
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7b5;
    cpuPkg::regIdx_t rs1;
    cpuPkg::regIdx_t rs2;
    cpuPkg::regIdx_t rd;
    cpuPkg::word_t   immI;
    cpuPkg::word_t   immS;
    cpuPkg::word_t   immB;
    cpuPkg::word_t   opA;
    cpuPkg::word_t   opB;

    // Predictions
    logic            isAlu;
    logic            isLoad;
    logic            isStore;
    logic            isBranch;
    logic            branchCond;
    logic            expRegWrite;
    logic            loadKnown;
    logic [5:0]      memIdx;
    cpuPkg::word_t   expWdata;
    cpuPkg::word_t   expMemAddr;
    cpuPkg::word_t   expNextPc;

    cpuTop u_cpuTop (
        .CLK    (CLK),
        .arstN  (arstN),
        .retire (retire)
    );

    always #2 CLK = ~CLK;

    always_comb begin
        opcode   = retire.inst[6:0];
        funct3   = retire.inst[14:12];
        funct7b5 = retire.inst[30];
        rs1      = retire.inst[19:15];
        rs2      = retire.inst[24:20];
        rd       = retire.inst[11:7];
        immI     = {{20{retire.inst[31]}}, retire.inst[31:20]};
        immS     = {{20{retire.inst[31]}}, retire.inst[31:25], retire.inst[11:7]};
        immB     = {{20{retire.inst[31]}}, retire.inst[7], retire.inst[30:25],
                    retire.inst[11:8], 1'b0};
        opA      = shadowReg[rs1];   // x0 entry never written
        opB      = shadowReg[rs2];
    end

    // ISA reference for the instruction at the shadow pc
    always_comb begin
        isAlu    = 1'b0;
        isLoad   = (opcode == 7'b0000011) && (funct3 == 3'b010);
        isStore  = (opcode == 7'b0100011) && (funct3 == 3'b010);
        isBranch = (opcode == 7'b1100011) && (funct3[2:1] == 2'b00);
        expWdata = '0;
        case (opcode)
            7'b0110011: begin
                isAlu = 1'b1;
                case (funct3)
                    3'b000:  expWdata = funct7b5 ? (opA - opB) : (opA + opB);
                    3'b010:  expWdata = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                    3'b110:  expWdata = opA | opB;
                    3'b111:  expWdata = opA & opB;
                    default: isAlu = 1'b0;
                endcase
            end
            7'b0010011: begin
                isAlu = 1'b1;
                case (funct3)
                    3'b000:  expWdata = opA + immI;
                    3'b110:  expWdata = opA | immI;
                    3'b111:  expWdata = opA & immI;
                    default: isAlu = 1'b0;
                endcase
            end
            default: ;
        endcase

        expMemAddr = isStore ? (opA + immS) : (opA + immI);
        memIdx     = expMemAddr[7:2];   // 64-word RAM
        loadKnown  = memKnown[memIdx];
        if (isLoad) begin
            expWdata = shadowMem[memIdx];
        end

        expRegWrite = (isAlu || isLoad) && (rd != 5'd0);
        branchCond  = funct3[0] ? (opA != opB) : (opA == opB);
        expNextPc   = (isBranch && branchCond) ? (shadowPc + immB) : (shadowPc + 32'd4);
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                shadowReg[i] <= '0;
            end
            for (int i = 0; i < 64; i++) begin
                memKnown[i] <= 1'b0;
            end
            shadowPc    <= '0;
            seenRetire  <= 1'b0;
            loopReached <= 1'b0;
        end else if (retire.valid) begin
            seenRetire <= 1'b1;
            shadowPc   <= expNextPc;
            if (expRegWrite) begin
                shadowReg[rd] <= expWdata;
            end
            if (isStore) begin
                shadowMem[memIdx] <= opB;
                memKnown[memIdx]  <= 1'b1;
            end
            if (retire.nextPc == retire.pc) begin
                loopReached <= 1'b1;   // Self-loop marks end of program
            end
        end
    end

    resetQuiet: assert property (@(posedge CLK) !arstN |-> !retire.valid)
        else begin
            errCount++;
            $display("** Error [reset] valid expected 0 actual %0b", $sampled(retire.valid));
        end

    firstPc: assert property (@(posedge CLK) (retire.valid && !seenRetire) |-> (retire.pc == 0))
        else begin
            errCount++;
            $display("** Error [reset] first pc expected 00000000 actual %h", $sampled(retire.pc));
        end

    pcTrack: assert property (@(posedge CLK) retire.valid |-> (retire.pc == shadowPc))
        else begin
            errCount++;
            $display("** Error [pc] expected %h actual %h",
                     $sampled(shadowPc), $sampled(retire.pc));
        end

    aluResult: assert property (
        @(posedge CLK) (retire.valid && isAlu && expRegWrite) |-> (retire.wdata == expWdata)
    ) else begin
        errCount++;
        $display("** Error [alu] pc %h expected %h actual %h",
                 $sampled(retire.pc), $sampled(expWdata), $sampled(retire.wdata));
    end

    regWriteFlag: assert property (
        @(posedge CLK) retire.valid |-> (retire.regWrite == expRegWrite)
    ) else begin
        errCount++;
        $display("** Error [regWrite] pc %h expected %0b actual %0b",
                 $sampled(retire.pc), $sampled(expRegWrite), $sampled(retire.regWrite));
    end

    // Destination index of a real register write
    rdIndex: assert property (
        @(posedge CLK) (retire.valid && expRegWrite) |-> (retire.rd == rd)
    ) else begin
        errCount++;
        $display("** Error [rd] pc %h expected %0d actual %0d",
                 $sampled(retire.pc), $sampled(rd), $sampled(retire.rd));
    end

    loadData: assert property (
        @(posedge CLK) (retire.valid && isLoad && loadKnown) |-> (retire.wdata == expWdata)
    ) else begin
        errCount++;
        $display("** Error [load] pc %h expected %h actual %h",
                 $sampled(retire.pc), $sampled(expWdata), $sampled(retire.wdata));
    end

    storeAddr: assert property (
        @(posedge CLK) (retire.valid && isStore) |-> (retire.memAddr == expMemAddr)
    ) else begin
        errCount++;
        $display("** Error [store addr] pc %h expected %h actual %h",
                 $sampled(retire.pc), $sampled(expMemAddr), $sampled(retire.memAddr));
    end

    storeData: assert property (
        @(posedge CLK) (retire.valid && isStore) |-> (retire.memData == opB)
    ) else begin
        errCount++;
        $display("** Error [store data] pc %h expected %h actual %h",
                 $sampled(retire.pc), $sampled(opB), $sampled(retire.memData));
    end

    memWriteFlag: assert property (
        @(posedge CLK) retire.valid |-> (retire.memWrite == isStore)
    ) else begin
        errCount++;
        $display("** Error [memWrite] pc %h expected %0b actual %0b",
                 $sampled(retire.pc), $sampled(isStore), $sampled(retire.memWrite));
    end

    nextPcCheck: assert property (
        @(posedge CLK) retire.valid |-> (retire.nextPc == expNextPc)
    ) else begin
        errCount++;
        $display("** Error [nextPc] pc %h expected %h actual %h",
                 $sampled(retire.pc), $sampled(expNextPc), $sampled(retire.nextPc));
    end

    initial begin
        errCount = 0;
        cycles   = 0;
        CLK      = 1'b0;
        arstN    = 1'b0;

        repeat (8) @(posedge CLK);
        arstN <= 1'b1;

        // Run until the program parks in its final loop
        while (!loopReached && cycles < runCycles) begin
            @(posedge CLK);
            cycles++;
        end
        if (!loopReached) begin
            errCount++;
            $display("Error: program never reached its final loop within %0d cycles", runCycles);
        end

        @(posedge CLK);
        #1;
        $display("Run finished after %0d cycles with %0d errors", cycles, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== cpuTop.f ====
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/dataMem.sv
logic/cpuTop.sv
dv/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuTop testbench with Verilator
# The ROM opens prog.hex from the working directory, so the model runs inside dv/

rm -f sim.log
verilator --binary --timing --assert -f cpuTop.f --top-module cpuTb -o VcpuTb \
    && (cd dv && ../obj_dir/VcpuTb) > sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== dv/prog.hex ====
// One 32-bit RV32I instruction per line, starting at byte address 0
// Column: instruction word in hex, then the assembly it encodes
00500093  // 00: addi x1, x0, 5
FFD00113  // 04: addi x2, x0, -3
002081B3  // 08: add  x3, x1, x2
40110233  // 0c: sub  x4, x2, x1
0020F2B3  // 10: and  x5, x1, x2
0020E333  // 14: or   x6, x1, x2
001123B3  // 18: slt  x7, x2, x1
0020A433  // 1c: slt  x8, x1, x2
0F017493  // 20: andi x9, x2, 0xf0
FF00E513  // 24: ori  x10, x1, -16
00708013  // 28: addi x0, x1, 7
001005B3  // 2c: add  x11, x0, x1
00C00613  // 30: addi x12, x0, 12
00462223  // 34: sw   x4, 4(x12)
00A62423  // 38: sw   x10, 8(x12)
00462683  // 3c: lw   x13, 4(x12)
00862703  // 40: lw   x14, 8(x12)
00468463  // 44: beq  x13, x4, +8  (taken)
00100793  // 48: addi x15, x0, 1   (skipped)
00208463  // 4c: beq  x1, x2, +8   (not taken)
00209463  // 50: bne  x1, x2, +8   (taken)
00200793  // 54: addi x15, x0, 2   (skipped)
00319463  // 58: bne  x3, x3, +8   (not taken)
00000063  // 5c: beq  x0, x0, 0    (final loop)
